//--- Bender.yml
package:
  name: exe_stage

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - exe_pkg.sv
      - exe_operand_sel.sv
      - exe_alu.sv
      - exe_branch_unit.sv
      - exe_div_unit.sv
      - exe_top.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb_exe_top.sv

//--- exe_alu.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module exe_alu (
    input  logic [`EXE_XLEN-1:0] op_a_i,
    input  logic [`EXE_XLEN-1:0] op_b_i,
    input  exe_pkg::op_e         op_i,
    input  logic                 op_32_i,
    output logic [`EXE_XLEN-1:0] result_o
);

    localparam int XLEN = `EXE_XLEN;

    logic [XLEN-1:0]         res_64;
    logic [31:0]             res_32;
    logic [$clog2(XLEN)-1:0] shamt_64;
    logic [4:0]              shamt_32;
    logic                    is_cmp;

    assign shamt_64 = op_b_i[$clog2(XLEN)-1:0];
    assign shamt_32 = op_b_i[4:0];  // W shifts use 5 bits
    assign is_cmp   = (op_i == exe_pkg::SLT) || (op_i == exe_pkg::SLTU);

    always_comb begin
        case (op_i)
            exe_pkg::ADD:  res_64 = op_a_i + op_b_i;
            exe_pkg::SUB:  res_64 = op_a_i - op_b_i;
            exe_pkg::AND:  res_64 = op_a_i & op_b_i;
            exe_pkg::OR:   res_64 = op_a_i | op_b_i;
            exe_pkg::XOR:  res_64 = op_a_i ^ op_b_i;
            exe_pkg::SLL:  res_64 = op_a_i << shamt_64;
            exe_pkg::SRL:  res_64 = op_a_i >> shamt_64;
            exe_pkg::SRA:  res_64 = $signed(op_a_i) >>> shamt_64;
            exe_pkg::SLT:  res_64 = {{(XLEN-1){1'b0}}, $signed(op_a_i) < $signed(op_b_i)};
            exe_pkg::SLTU: res_64 = {{(XLEN-1){1'b0}}, op_a_i < op_b_i};
            default:       res_64 = '0;
        endcase
    end

    // Low word path for the W variants
    always_comb begin
        case (op_i)
            exe_pkg::ADD: res_32 = op_a_i[31:0] + op_b_i[31:0];
            exe_pkg::SUB: res_32 = op_a_i[31:0] - op_b_i[31:0];
            exe_pkg::AND: res_32 = op_a_i[31:0] & op_b_i[31:0];
            exe_pkg::OR:  res_32 = op_a_i[31:0] | op_b_i[31:0];
            exe_pkg::XOR: res_32 = op_a_i[31:0] ^ op_b_i[31:0];
            exe_pkg::SLL: res_32 = op_a_i[31:0] << shamt_32;
            exe_pkg::SRL: res_32 = op_a_i[31:0] >> shamt_32;
            exe_pkg::SRA: res_32 = $signed(op_a_i[31:0]) >>> shamt_32;
            default:      res_32 = '0;
        endcase
    end

    assign result_o = (op_32_i && !is_cmp) ? {{(XLEN-32){res_32[31]}}, res_32} : res_64;

endmodule

//--- exe_branch_unit.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module exe_branch_unit (
    input  exe_pkg::op_e         op_i,
    input  logic [`EXE_XLEN-1:0] pc_i,
    input  logic [`EXE_XLEN-1:0] rs1_i,
    input  logic [`EXE_XLEN-1:0] rs2_i,
    input  logic [`EXE_XLEN-1:0] imm_i,
    output logic                 taken_o,
    output logic [`EXE_XLEN-1:0] target_o,
    output logic [`EXE_XLEN-1:0] link_o
);

    logic [`EXE_XLEN-1:0] jalr_sum;
    logic                 eq;
    logic                 lt_s;
    logic                 lt_u;

    assign eq   = (rs1_i == rs2_i);
    assign lt_s = $signed(rs1_i) < $signed(rs2_i);
    assign lt_u = rs1_i < rs2_i;

    // Condition evaluation
    always_comb begin
        case (op_i)
            exe_pkg::BEQ:  taken_o = eq;
            exe_pkg::BNE:  taken_o = !eq;
            exe_pkg::BLT:  taken_o = lt_s;
            exe_pkg::BGE:  taken_o = !lt_s;
            exe_pkg::BLTU: taken_o = lt_u;
            exe_pkg::BGEU: taken_o = !lt_u;
            exe_pkg::JAL,
            exe_pkg::JALR: taken_o = 1'b1;  // Unconditional
            default:       taken_o = 1'b0;
        endcase
    end

    assign jalr_sum = rs1_i + imm_i;

    // JALR clears bit 0 and leaves bit 1 for the misalign check
    assign target_o = (op_i == exe_pkg::JALR) ? {jalr_sum[`EXE_XLEN-1:1], 1'b0} : pc_i + imm_i;

    assign link_o = pc_i + `EXE_XLEN'd4;

endmodule

//--- exe_config.svh
`ifndef EXE_CONFIG_SVH
`define EXE_CONFIG_SVH

// ----------------------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------------------

// Data and PC width
`define EXE_XLEN 64

// Register file address width
`define EXE_REG_ADDR_W 5

// ----------------------------------------------------------------------
// Divider
// ----------------------------------------------------------------------

// One quotient bit per cycle, so one cycle per data bit
`define EXE_DIV_CYCLES `EXE_XLEN

`endif

//--- exe_div_unit.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module exe_div_unit (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 kill_i,
    input  logic                 request_i,
    input  logic                 signed_i,
    input  logic                 op_32_i,
    input  logic [`EXE_XLEN-1:0] dividend_i,
    input  logic [`EXE_XLEN-1:0] divisor_i,
    output logic [`EXE_XLEN-1:0] quotient_o,
    output logic [`EXE_XLEN-1:0] remainder_o,
    output logic                 stall_o,
    output logic                 done_o
);

    localparam int XLEN  = `EXE_XLEN;
    localparam int CNT_W = $clog2(`EXE_DIV_CYCLES + 1);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } div_state_e;

    div_state_e       state_q;
    logic [CNT_W-1:0] cnt_q;

    logic [XLEN-1:0] dvnd_ext;
    logic [XLEN-1:0] dvsr_ext;
    logic [XLEN-1:0] dvnd_mag;
    logic [XLEN-1:0] dvsr_mag;
    logic            dvnd_neg;
    logic            dvsr_neg;

    logic [XLEN-1:0] quo_q;     // Dividend bits shift out, quotient bits in
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] dvsr_q;
    logic            neg_quo_q;
    logic            neg_rem_q;
    logic            div_zero_q;
    logic            op_32_q;

    logic [XLEN:0]   rem_shift;
    logic [XLEN:0]   rem_trial;
    logic [XLEN-1:0] quo_sgn;
    logic [XLEN-1:0] rem_sgn;

    // ----------------------------------------------------------------------
    // Operand preparation
    // ----------------------------------------------------------------------

    always_comb begin
        if (op_32_i) begin
            dvnd_ext = {{(XLEN-32){signed_i & dividend_i[31]}}, dividend_i[31:0]};
            dvsr_ext = {{(XLEN-32){signed_i & divisor_i[31]}}, divisor_i[31:0]};
        end else begin
            dvnd_ext = dividend_i;
            dvsr_ext = divisor_i;
        end
    end

    assign dvnd_neg = signed_i & dvnd_ext[XLEN-1];
    assign dvsr_neg = signed_i & dvsr_ext[XLEN-1];
    assign dvnd_mag = dvnd_neg ? -dvnd_ext : dvnd_ext;  // Most negative stays 2^(XLEN-1)
    assign dvsr_mag = dvsr_neg ? -dvsr_ext : dvsr_ext;

    // Restoring step where a set top bit marks a borrow
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign rem_trial = rem_shift - {1'b0, dvsr_q};

    // ----------------------------------------------------------------------
    // Control
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (request_i && !kill_i) begin
                        state_q <= BUSY;
                        cnt_q   <= CNT_W'(`EXE_DIV_CYCLES - 1);
                    end
                end
                BUSY: begin
                    if (kill_i) begin
                        state_q <= IDLE;  // Abort
                    end else if (cnt_q == '0) begin
                        state_q <= DONE;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: state_q <= IDLE;  // DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE) begin
            quo_q      <= dvnd_mag;
            rem_q      <= '0;
            dvsr_q     <= dvsr_mag;
            neg_quo_q  <= dvnd_neg ^ dvsr_neg;
            neg_rem_q  <= dvnd_neg;               // Remainder follows dividend
            div_zero_q <= (dvsr_ext == '0);
            op_32_q    <= op_32_i;
        end else if (state_q == BUSY) begin
            quo_q <= {quo_q[XLEN-2:0], ~rem_trial[XLEN]};
            rem_q <= rem_trial[XLEN] ? rem_shift[XLEN-1:0] : rem_trial[XLEN-1:0];
        end
    end

    // ----------------------------------------------------------------------
    // Result fix-up
    // ----------------------------------------------------------------------

    // Signed overflow is covered as 2^(XLEN-1) negated wraps to itself
    // Division by zero leaves the dividend magnitude in rem_q
    assign quo_sgn = div_zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
    assign rem_sgn = neg_rem_q ? -rem_q : rem_q;

    assign quotient_o  = op_32_q ? {{(XLEN-32){quo_sgn[31]}}, quo_sgn[31:0]} : quo_sgn;
    assign remainder_o = op_32_q ? {{(XLEN-32){rem_sgn[31]}}, rem_sgn[31:0]} : rem_sgn;

    always_comb begin
        case (state_q)
            IDLE:    stall_o = request_i;  // Request cycle already stalls
            BUSY:    stall_o = 1'b1;
            default: stall_o = 1'b0;
        endcase
    end

    assign done_o = (state_q == DONE);

endmodule

//--- exe_operand_sel.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module exe_operand_sel (
    input  exe_pkg::rr_exe_instr_t from_rr_i,
    input  exe_pkg::wb_exe_instr_t from_wb_i,
    output logic [`EXE_XLEN-1:0]   rs1_fwd_o,
    output logic [`EXE_XLEN-1:0]   rs2_fwd_o,
    output logic [`EXE_XLEN-1:0]   op_a_o,
    output logic [`EXE_XLEN-1:0]   op_b_o
);

    logic hit_rs1;
    logic hit_rs2;

    // Write-back bypass that never forwards x0
    assign hit_rs1 = from_wb_i.valid && (from_wb_i.rd != '0) &&
                     (from_wb_i.rd == from_rr_i.rs1);
    assign hit_rs2 = from_wb_i.valid && (from_wb_i.rd != '0) &&
                     (from_wb_i.rd == from_rr_i.rs2);

    assign rs1_fwd_o = hit_rs1 ? from_wb_i.data : from_rr_i.data_rs1;
    assign rs2_fwd_o = hit_rs2 ? from_wb_i.data : from_rr_i.data_rs2;

    // ALU operands
    assign op_a_o = from_rr_i.use_pc  ? from_rr_i.pc  : rs1_fwd_o;  // AUIPC style
    assign op_b_o = from_rr_i.use_imm ? from_rr_i.imm : rs2_fwd_o;

endmodule

//--- exe_pkg.sv
`include "exe_config.svh"

package exe_pkg;

    typedef logic [`EXE_XLEN-1:0]       bus_t;
    typedef logic [`EXE_REG_ADDR_W-1:0] reg_addr_t;

    // Functional unit selected by decode
    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_DIV,
        UNIT_BRANCH,
        UNIT_SYSTEM
    } unit_e;

    typedef enum logic [4:0] {
        // ALU group
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
        // Branch group
        BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR,
        // Divider group
        DIV, DIVU, REM, REMU
    } op_e;

    // Encodings follow the mcause values
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_ACCESS_FAULT    = 4'd1,
        ILLEGAL_INSTR         = 4'd2,
        BREAKPOINT            = 4'd3,
        USER_ECALL            = 4'd8,
        INSTR_PAGE_FAULT      = 4'd12
    } xcpt_cause_e;

    typedef struct packed {
        logic        valid;
        xcpt_cause_e cause;
        bus_t        origin;  // Faulting address
    } xcpt_t;

    // ----------------------------------------------------------------------
    // Stage interfaces
    // ----------------------------------------------------------------------

    typedef struct packed {
        logic      valid;
        bus_t      pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        bus_t      data_rs1;
        bus_t      data_rs2;
        bus_t      imm;
        logic      use_imm;     // Immediate as second operand
        logic      use_pc;      // PC as first operand
        logic      op_32;       // W variant
        logic      regfile_we;
        unit_e     unit;
        op_e       op;
        xcpt_t     ex;          // Raised by earlier stages
    } rr_exe_instr_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        bus_t      data;
    } wb_exe_instr_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      regfile_we;
        bus_t      result_rd;
        bus_t      result_pc;
        logic      branch_taken;
        xcpt_t     ex;
    } exe_wb_instr_t;

endpackage

//--- exe_top.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module exe_top (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   kill_i,
    input  exe_pkg::rr_exe_instr_t from_rr_i,
    input  exe_pkg::wb_exe_instr_t from_wb_i,
    output exe_pkg::exe_wb_instr_t to_wb_o,
    output logic                   stall_o
);

    logic [`EXE_XLEN-1:0] rs1_fwd;
    logic [`EXE_XLEN-1:0] rs2_fwd;
    logic [`EXE_XLEN-1:0] op_a;
    logic [`EXE_XLEN-1:0] op_b;
    logic [`EXE_XLEN-1:0] result_alu;
    logic [`EXE_XLEN-1:0] quotient;
    logic [`EXE_XLEN-1:0] remainder;
    logic [`EXE_XLEN-1:0] target;
    logic [`EXE_XLEN-1:0] link;
    logic [`EXE_XLEN-1:0] result_rd;
    logic                 taken;
    logic                 div_req;
    logic                 div_signed;
    logic                 div_stall;
    logic                 div_done;
    logic                 is_branch;
    exe_pkg::xcpt_t       ex;

    exe_operand_sel i_operand_sel (
        .from_rr_i (from_rr_i),
        .from_wb_i (from_wb_i),
        .rs1_fwd_o (rs1_fwd),
        .rs2_fwd_o (rs2_fwd),
        .op_a_o    (op_a),
        .op_b_o    (op_b)
    );

    exe_alu i_alu (
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .op_i     (from_rr_i.op),
        .op_32_i  (from_rr_i.op_32),
        .result_o (result_alu)
    );

    exe_branch_unit i_branch_unit (
        .op_i     (from_rr_i.op),
        .pc_i     (from_rr_i.pc),
        .rs1_i    (rs1_fwd),
        .rs2_i    (rs2_fwd),
        .imm_i    (from_rr_i.imm),
        .taken_o  (taken),
        .target_o (target),
        .link_o   (link)
    );

    assign div_req    = from_rr_i.valid && (from_rr_i.unit == exe_pkg::UNIT_DIV);
    assign div_signed = (from_rr_i.op == exe_pkg::DIV) || (from_rr_i.op == exe_pkg::REM);

    exe_div_unit i_div_unit (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .kill_i      (kill_i),
        .request_i   (div_req),
        .signed_i    (div_signed),
        .op_32_i     (from_rr_i.op_32),
        .dividend_i  (rs1_fwd),
        .divisor_i   (rs2_fwd),  // No immediate form for divides
        .quotient_o  (quotient),
        .remainder_o (remainder),
        .stall_o     (div_stall),
        .done_o      (div_done)
    );

    // ----------------------------------------------------------------------
    // Result and exception
    // ----------------------------------------------------------------------

    assign is_branch = (from_rr_i.unit == exe_pkg::UNIT_BRANCH);

    always_comb begin
        case (from_rr_i.unit)
            exe_pkg::UNIT_ALU:    result_rd = result_alu;
            exe_pkg::UNIT_DIV:    result_rd = (from_rr_i.op == exe_pkg::REM ||
                                               from_rr_i.op == exe_pkg::REMU) ? remainder
                                                                              : quotient;
            exe_pkg::UNIT_BRANCH: result_rd = link;
            default:              result_rd = rs1_fwd;  // SYSTEM
        endcase
    end

    always_comb begin
        if (from_rr_i.ex.valid) begin
            ex = from_rr_i.ex;  // Earlier stage wins
        end else if (from_rr_i.valid && is_branch && taken && (target[1:0] != 2'b00)) begin
            ex.valid  = 1'b1;
            ex.cause  = exe_pkg::INSTR_ADDR_MISALIGNED;
            ex.origin = target;
        end else begin
            ex.valid  = 1'b0;
            ex.cause  = exe_pkg::INSTR_ADDR_MISALIGNED;
            ex.origin = '0;
        end
    end

    // Divides report only on their done cycle
    assign to_wb_o.valid        = from_rr_i.valid && (!div_req || div_done);
    assign to_wb_o.rd           = from_rr_i.rd;
    assign to_wb_o.regfile_we   = from_rr_i.regfile_we;
    assign to_wb_o.result_rd    = result_rd;
    assign to_wb_o.result_pc    = is_branch ? target : '0;
    assign to_wb_o.branch_taken = is_branch && taken;
    assign to_wb_o.ex           = ex;

    assign stall_o = div_req && div_stall;

endmodule

//--- tb.f
+incdir+.
exe_pkg.sv
exe_operand_sel.sv
exe_alu.sv
exe_branch_unit.sv
exe_div_unit.sv
exe_top.sv
tb_exe_top.sv

//--- tb_exe_top.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module tb_exe_top;

    typedef logic [`EXE_XLEN-1:0] word_t;

    typedef struct packed {
        exe_pkg::rr_exe_instr_t rr;
        exe_pkg::wb_exe_instr_t wb;
        word_t                  exp_rd;
        word_t                  exp_pc;
        logic                   exp_taken;
        exe_pkg::xcpt_t         exp_ex;
        logic [7:0]             kill_after;  // Cycles into a divide before a kill pulse
    } test_t;

    logic                   clk_i;
    logic                   rst_i;
    logic                   kill_i;
    exe_pkg::rr_exe_instr_t from_rr_i;
    exe_pkg::wb_exe_instr_t from_wb_i;
    exe_pkg::exe_wb_instr_t to_wb_o;
    logic                   stall_o;

    test_t  tests[$];
    string  names[$];
    test_t  cur;
    string  cur_name;
    integer seed;
    int     errors;
    int     cycles;
    logic   table_ready;

    exe_top i_exe_top (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .kill_i    (kill_i),
        .from_rr_i (from_rr_i),
        .from_wb_i (from_wb_i),
        .to_wb_o   (to_wb_o),
        .stall_o   (stall_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ----------------------------------------------------------------------
    // Reference model and table helpers
    // ----------------------------------------------------------------------

    // RISC-V division rules with truncation toward zero
    function automatic word_t div_model(input exe_pkg::op_e op, input logic op_32,
                                        input word_t a, input word_t b);
        logic        sgn;
        logic [31:0] q32;
        logic [31:0] r32;
        word_t       q;
        word_t       r;
        sgn = (op == exe_pkg::DIV) || (op == exe_pkg::REM);
        if (op_32) begin
            if (b[31:0] == '0) begin
                q32 = '1;
                r32 = a[31:0];
            end else if (sgn && a[31:0] == 32'h8000_0000 && b[31:0] == '1) begin
                q32 = a[31:0];
                r32 = '0;
            end else if (sgn) begin
                q32 = $signed(a[31:0]) / $signed(b[31:0]);
                r32 = $signed(a[31:0]) % $signed(b[31:0]);
            end else begin
                q32 = a[31:0] / b[31:0];
                r32 = a[31:0] % b[31:0];
            end
            q = {{(`EXE_XLEN-32){q32[31]}}, q32};
            r = {{(`EXE_XLEN-32){r32[31]}}, r32};
        end else if (b == '0) begin
            q = '1;
            r = a;
        end else if (sgn && a == {1'b1, {(`EXE_XLEN-1){1'b0}}} && b == '1) begin
            q = a;
            r = '0;
        end else if (sgn) begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        return (op == exe_pkg::REM || op == exe_pkg::REMU) ? r : q;
    endfunction

    task automatic new_test(input string name, input exe_pkg::unit_e unit,
                            input exe_pkg::op_e op, input logic op_32,
                            input word_t a, input word_t b);
        cur_name          = name;
        cur               = '0;
        cur.rr.valid      = 1'b1;
        cur.rr.pc         = 64'h1000;
        cur.rr.rs1        = 5'd1;
        cur.rr.rs2        = 5'd2;
        cur.rr.rd         = 5'd3;
        cur.rr.regfile_we = 1'b1;
        cur.rr.data_rs1   = a;
        cur.rr.data_rs2   = b;
        cur.rr.op_32      = op_32;
        cur.rr.unit       = unit;
        cur.rr.op         = op;
    endtask

    task automatic push_test(input word_t exp_rd);
        cur.exp_rd = exp_rd;
        tests.push_back(cur);
        names.push_back(cur_name);
    endtask

    task automatic set_wb(input logic valid, input logic [4:0] rd, input word_t data);
        cur.wb.valid = valid;
        cur.wb.rd    = rd;
        cur.wb.data  = data;
    endtask

    task automatic set_ex_in(input exe_pkg::xcpt_cause_e cause, input word_t origin);
        cur.rr.ex.valid  = 1'b1;
        cur.rr.ex.cause  = cause;
        cur.rr.ex.origin = origin;
        cur.exp_ex       = cur.rr.ex;  // Passed on unchanged
    endtask

    task automatic alu_test(input string name, input exe_pkg::op_e op, input logic op_32,
                            input word_t a, input word_t b, input word_t exp_rd);
        new_test(name, exe_pkg::UNIT_ALU, op, op_32, a, b);
        push_test(exp_rd);
    endtask

    task automatic div_test(input string name, input exe_pkg::op_e op, input logic op_32,
                            input word_t a, input word_t b, input word_t exp_rd);
        new_test(name, exe_pkg::UNIT_DIV, op, op_32, a, b);
        push_test(exp_rd);
    endtask

    task automatic branch_test(input string name, input exe_pkg::op_e op, input word_t a,
                               input word_t b, input word_t imm, input logic taken,
                               input word_t target);
        new_test(name, exe_pkg::UNIT_BRANCH, op, 1'b0, a, b);
        cur.rr.imm        = imm;
        cur.rr.regfile_we = (op == exe_pkg::JAL) || (op == exe_pkg::JALR);  // Only jumps link
        cur.exp_pc        = target;
        cur.exp_taken     = taken;
        if (taken && target[1:0] != 2'b00) begin  // Jump to a misaligned target
            cur.exp_ex.valid  = 1'b1;
            cur.exp_ex.cause  = exe_pkg::INSTR_ADDR_MISALIGNED;
            cur.exp_ex.origin = target;
        end
        push_test(64'h1004);  // Link is PC+4
    endtask

    task automatic build_table();
        exe_pkg::op_e div_ops[4];
        exe_pkg::op_e op;
        word_t        a;
        word_t        b;
        div_ops = '{exe_pkg::DIV, exe_pkg::DIVU, exe_pkg::REM, exe_pkg::REMU};
        alu_test("add", exe_pkg::ADD, 1'b0, 64'd5, 64'd3, 64'd8);
        alu_test("sub_neg", exe_pkg::SUB, 1'b0, 64'd3, 64'd5, 64'hffff_ffff_ffff_fffe);
        alu_test("and", exe_pkg::AND, 1'b0, 64'hf0f0, 64'hff00, 64'hf000);
        alu_test("or", exe_pkg::OR, 1'b0, 64'hf0f0, 64'h0f0f, 64'hffff);
        alu_test("xor", exe_pkg::XOR, 1'b0, 64'hff00, 64'h0ff0, 64'hf0f0);
        alu_test("sll_40", exe_pkg::SLL, 1'b0, 64'd1, 64'd40, 64'h0000_0100_0000_0000);
        alu_test("srl_63", exe_pkg::SRL, 1'b0, 64'h8000_0000_0000_0000, 64'd63, 64'd1);
        alu_test("sra_36", exe_pkg::SRA, 1'b0, 64'h8000_0000_0000_0000, 64'd36,
                 64'hffff_ffff_f800_0000);
        alu_test("slt", exe_pkg::SLT, 1'b0, '1, 64'd1, 64'd1);
        alu_test("sltu", exe_pkg::SLTU, 1'b0, '1, 64'd1, 64'd0);
        alu_test("slt_op32", exe_pkg::SLT, 1'b1, 64'h8000_0000, 64'd1, 64'd0);
        alu_test("addw_ovf", exe_pkg::ADD, 1'b1, 64'h7fff_ffff, 64'd1, 64'hffff_ffff_8000_0000);
        alu_test("subw", exe_pkg::SUB, 1'b1, 64'h1_0000_0000, 64'd1, '1);
        alu_test("sllw_33", exe_pkg::SLL, 1'b1, 64'd1, 64'd33, 64'd2);
        alu_test("srlw", exe_pkg::SRL, 1'b1, 64'hffff_ffff_8000_0000, 64'd4, 64'h0800_0000);
        alu_test("sraw", exe_pkg::SRA, 1'b1, 64'h8000_0000, 64'd4, 64'hffff_ffff_f800_0000);
        new_test("addi_neg", exe_pkg::UNIT_ALU, exe_pkg::ADD, 1'b0, 64'd100, 64'd7);
        cur.rr.use_imm = 1'b1;
        cur.rr.imm     = 64'hffff_ffff_ffff_fffc;
        push_test(64'd96);
        new_test("auipc", exe_pkg::UNIT_ALU, exe_pkg::ADD, 1'b0, 64'd5, 64'd7);
        cur.rr.pc      = 64'h8000_1000;
        cur.rr.use_pc  = 1'b1;
        cur.rr.use_imm = 1'b1;
        cur.rr.imm     = 64'h2000;
        push_test(64'h8000_3000);

        // Forwarding from write-back
        new_test("fwd_rs1", exe_pkg::UNIT_ALU, exe_pkg::ADD, 1'b0, 64'd10, 64'd20);
        set_wb(1'b1, 5'd1, 64'd100);
        push_test(64'd120);
        new_test("fwd_rs2", exe_pkg::UNIT_ALU, exe_pkg::ADD, 1'b0, 64'd10, 64'd20);
        set_wb(1'b1, 5'd2, 64'd1000);
        push_test(64'd1010);
        new_test("fwd_x0", exe_pkg::UNIT_ALU, exe_pkg::ADD, 1'b0, 64'd10, 64'd20);
        cur.rr.rs1 = 5'd0;
        set_wb(1'b1, 5'd0, 64'd100);
        push_test(64'd30);
        new_test("fwd_wb_invalid", exe_pkg::UNIT_ALU, exe_pkg::ADD, 1'b0, 64'd10, 64'd20);
        set_wb(1'b0, 5'd1, 64'd100);
        push_test(64'd30);
        new_test("system_fwd", exe_pkg::UNIT_SYSTEM, exe_pkg::ADD, 1'b0, 64'h1234, 64'd0);
        set_wb(1'b1, 5'd1, 64'habcd);
        push_test(64'habcd);

        // Branches, jumps and target alignment
        branch_test("beq_taken", exe_pkg::BEQ, 64'd5, 64'd5, 64'h40, 1'b1, 64'h1040);
        branch_test("beq_not_taken", exe_pkg::BEQ, 64'd5, 64'd6, 64'h40, 1'b0, 64'h1040);
        branch_test("bne_taken", exe_pkg::BNE, 64'd5, 64'd6, 64'h40, 1'b1, 64'h1040);
        branch_test("blt_taken", exe_pkg::BLT, '1, 64'd1, 64'h40, 1'b1, 64'h1040);
        branch_test("bge_not_taken", exe_pkg::BGE, '1, 64'd1, 64'h40, 1'b0, 64'h1040);
        branch_test("bltu_not_taken", exe_pkg::BLTU, '1, 64'd1, 64'h40, 1'b0, 64'h1040);
        branch_test("bgeu_taken", exe_pkg::BGEU, '1, 64'd1, 64'h40, 1'b1, 64'h1040);
        branch_test("jal", exe_pkg::JAL, 64'd0, 64'd0, 64'h100, 1'b1, 64'h1100);
        branch_test("jalr_bit0", exe_pkg::JALR, 64'h2001, 64'd0, 64'h10, 1'b1, 64'h2010);
        branch_test("jalr_misaligned", exe_pkg::JALR, 64'h2002, 64'd0, 64'h0, 1'b1, 64'h2002);
        branch_test("beq_misaligned", exe_pkg::BEQ, 64'd5, 64'd5, 64'h42, 1'b1, 64'h1042);
        branch_test("bne_misaligned_nt", exe_pkg::BNE, 64'd5, 64'd5, 64'h42, 1'b0, 64'h1042);

        // Exceptions from earlier stages
        new_test("alu_ex_in", exe_pkg::UNIT_ALU, exe_pkg::ADD, 1'b0, 64'd5, 64'd3);
        set_ex_in(exe_pkg::ILLEGAL_INSTR, 64'h1000);
        push_test(64'd8);
        new_test("jalr_ex_in", exe_pkg::UNIT_BRANCH, exe_pkg::JALR, 1'b0, 64'h2002, 64'd0);
        cur.exp_pc    = 64'h2002;
        cur.exp_taken = 1'b1;
        set_ex_in(exe_pkg::INSTR_PAGE_FAULT, 64'h3000);
        push_test(64'h1004);

        // Divider corner cases
        div_test("div_neg", exe_pkg::DIV, 1'b0, 64'd20, -64'sd3, -64'sd6);
        div_test("rem_neg_dvsr", exe_pkg::REM, 1'b0, 64'd20, -64'sd3, 64'd2);
        div_test("rem_neg_dvnd", exe_pkg::REM, 1'b0, -64'sd20, 64'd3, -64'sd2);
        div_test("divu_zero", exe_pkg::DIVU, 1'b0, 64'd123, 64'd0, '1);
        div_test("rem_zero", exe_pkg::REM, 1'b0, -64'sd7, 64'd0, -64'sd7);
        div_test("div_ovf", exe_pkg::DIV, 1'b0, 64'h8000_0000_0000_0000, '1,
                 64'h8000_0000_0000_0000);
        div_test("rem_ovf", exe_pkg::REM, 1'b0, 64'h8000_0000_0000_0000, '1, 64'd0);
        div_test("divw_ovf", exe_pkg::DIV, 1'b1, 64'h8000_0000, 64'hffff_ffff,
                 64'hffff_ffff_8000_0000);
        div_test("divuw", exe_pkg::DIVU, 1'b1, 64'hffff_ffff_ffff_fff0, 64'd2, 64'h7fff_fff8);
        div_test("remw", exe_pkg::REM, 1'b1, -64'sd7, 64'h1_0000_0003, '1);
        div_test("remuw_zero", exe_pkg::REMU, 1'b1, 64'h1234_5678_8000_0001, 64'h1_0000_0000,
                 64'hffff_ffff_8000_0001);
        new_test("divu_fwd", exe_pkg::UNIT_DIV, exe_pkg::DIVU, 1'b0, 64'd100, 64'd7);
        set_wb(1'b1, 5'd2, 64'd10);
        push_test(64'd10);
        new_test("divu_kill", exe_pkg::UNIT_DIV, exe_pkg::DIVU, 1'b0, '1, 64'd3);
        cur.kill_after = 8'd20;
        push_test(64'h5555_5555_5555_5555);
        div_test("divu_after_kill", exe_pkg::DIVU, 1'b0, 64'd1000, 64'd7, 64'd142);

        for (int i = 0; i < 8; i++) begin
            a  = {$random(seed), $random(seed)};
            b  = {$random(seed), $random(seed)};
            op = div_ops[i % 4];
            if ((i / 2) % 2 == 1) begin
                b = b >> 40;  // Short divisor for a long quotient
            end
            div_test($sformatf("div_rand_%0d", i), op, i >= 4, a, b,
                     div_model(op, i >= 4, a, b));
        end
    endtask

    // ----------------------------------------------------------------------
    // Checking
    // ----------------------------------------------------------------------

    task automatic check_field(input string name, input string field,
                               input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            errors++;
            $display("mismatch %s %s expected %h actual %h", name, field, expected, actual);
        end
    endtask

    task automatic run_test(input string name, input test_t t);
        int stall_cycles;
        stall_cycles = 0;
        @(posedge clk_i);
        from_rr_i <= t.rr;
        from_wb_i <= t.wb;
        @(negedge clk_i);
        if (t.kill_after != 0) begin
            repeat (t.kill_after) @(negedge clk_i);
            @(posedge clk_i);
            kill_i <= 1'b1;
            @(posedge clk_i);
            kill_i <= 1'b0;  // Held instruction restarts from an idle divider
            @(negedge clk_i);
        end
        if (t.rr.unit == exe_pkg::UNIT_DIV) begin
            while (stall_o && stall_cycles < `EXE_DIV_CYCLES + 4) begin
                stall_cycles++;
                @(negedge clk_i);
            end
            assert (!stall_o) else begin
                errors++;
                $display("divider in test %s never dropped its stall", name);
            end
            check_field(name, "stall cycles", `EXE_DIV_CYCLES + 1, stall_cycles);
        end else begin
            check_field(name, "stall_o", 0, stall_o);  // Single-cycle units
        end
        check_field(name, "valid", 1, to_wb_o.valid);
        check_field(name, "rd", t.rr.rd, to_wb_o.rd);
        check_field(name, "regfile_we", t.rr.regfile_we, to_wb_o.regfile_we);
        check_field(name, "result_rd", t.exp_rd, to_wb_o.result_rd);
        check_field(name, "result_pc", t.exp_pc, to_wb_o.result_pc);
        check_field(name, "branch_taken", t.exp_taken, to_wb_o.branch_taken);
        check_field(name, "ex.valid", t.exp_ex.valid, to_wb_o.ex.valid);
        if (t.exp_ex.valid) begin
            check_field(name, "ex.cause", t.exp_ex.cause, to_wb_o.ex.cause);
            check_field(name, "ex.origin", t.exp_ex.origin, to_wb_o.ex.origin);
        end
    endtask

    // ----------------------------------------------------------------------
    // Run control
    // ----------------------------------------------------------------------

    initial begin
        int limit;
        cycles = 0;
        wait (table_ready === 1'b1);
        limit = tests.size() * (`EXE_DIV_CYCLES + 8);
        while (cycles < limit) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("run stopped after %0d cycles without finishing", cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        seed        = 32'hfe7d;
        errors      = 0;
        table_ready = 1'b0;
        rst_i       = 1'b1;
        kill_i      = 1'b0;
        from_rr_i   = '0;
        from_wb_i   = '0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;
        for (int i = 0; i < tests.size(); i++) begin
            run_test(names[i], tests[i]);
        end
        @(posedge clk_i);
        from_rr_i <= '0;
        from_wb_i <= '0;
        @(negedge clk_i);
        $display("tests: %0d errors: %0d", tests.size(), errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
